//--- logic/apb_access_fsm.sv
`default_nettype none
`timescale 1ns/1ps

`include "periph_cfg.svh"

module apb_access_fsm (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    // APB slave
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  periph_bus_pkg::apb_addr_t   paddr_i,
    input  periph_bus_pkg::apb_data_t   pwdata_i,
    output periph_bus_pkg::apb_data_t   prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    // Register requests
    output logic                        plic_req_o,
    output logic                        tmr_req_o,
    output logic                        req_write_o,
    output periph_bus_pkg::reg_offset_t req_offset_o,
    output periph_bus_pkg::apb_data_t   req_wdata_o,
    input  periph_bus_pkg::apb_data_t   plic_rdata_i,
    input  periph_bus_pkg::apb_data_t   tmr_rdata_i
);

    localparam periph_bus_pkg::apb_addr_t PAGE_MASK =
        ~periph_bus_pkg::apb_addr_t'((1 << `PERIPH_OFFSET_W) - 1);

    periph_bus_pkg::access_state_e state_q;
    periph_bus_pkg::access_state_e state_d;
    periph_bus_pkg::slot_e         slot;
    periph_bus_pkg::apb_addr_t     page;
    periph_bus_pkg::apb_data_t     rdata_q;
    logic                          slverr_q;
    logic                          strobe;

    // --------------------
    // Slot decode
    // --------------------
    assign page = paddr_i & PAGE_MASK;

    always_comb begin
        if (page == `PERIPH_PLIC_BASE) begin
            slot = periph_bus_pkg::SLOT_PLIC;
        end else if (page == `PERIPH_TIMER_BASE) begin
            slot = periph_bus_pkg::SLOT_TIMER;
        end else begin
            slot = periph_bus_pkg::SLOT_ERR;
        end
    end

    // --------------------
    // Access sequence
    // --------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            periph_bus_pkg::ST_IDLE: begin
                // Leaving on the setup phase puts the strobe in the first access cycle
                if (psel_i && !penable_i) begin
                    state_d = periph_bus_pkg::ST_STROBE;
                end
            end
            periph_bus_pkg::ST_STROBE: state_d = periph_bus_pkg::ST_READY;
            default:                   state_d = periph_bus_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= periph_bus_pkg::ST_IDLE;
            slverr_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            slverr_q <= strobe && (slot == periph_bus_pkg::SLOT_ERR);
        end
    end

    assign strobe = (state_q == periph_bus_pkg::ST_STROBE);

    // One strobe per data module
    assign plic_req_o   = strobe && (slot == periph_bus_pkg::SLOT_PLIC);
    assign tmr_req_o    = strobe && (slot == periph_bus_pkg::SLOT_TIMER);
    assign req_write_o  = pwrite_i;
    assign req_offset_o = paddr_i[`PERIPH_OFFSET_W-1:0];
    assign req_wdata_o  = pwdata_i;

    // Read data held through ST_READY
    always_ff @(posedge clk_i) begin
        if (strobe) begin
            case (slot)
                periph_bus_pkg::SLOT_PLIC:  rdata_q <= plic_rdata_i;
                periph_bus_pkg::SLOT_TIMER: rdata_q <= tmr_rdata_i;
                default:                    rdata_q <= `PERIPH_ERR_PATTERN;
            endcase
        end
    end

    assign prdata_o  = rdata_q;
    assign pready_o  = (state_q == periph_bus_pkg::ST_READY);
    assign pslverr_o = slverr_q;

    a_penable_with_psel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        penable_i |-> psel_i);

    a_ready_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pready_o |=> !pready_o);

endmodule

`default_nettype wire

//--- logic/irq_controller.sv
`default_nettype none
`timescale 1ns/1ps

`include "periph_cfg.svh"

module irq_controller (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        req_i,
    input  logic                        write_i,
    input  periph_bus_pkg::reg_offset_t offset_i,
    input  periph_bus_pkg::apb_data_t   wdata_i,
    output periph_bus_pkg::apb_data_t   rdata_o,
    input  periph_irq_pkg::irq_vec_t    src_i,
    output logic                        irq_o
);

    localparam int NSRC = periph_irq_pkg::NUM_SRC;

    localparam periph_bus_pkg::reg_offset_t OFF_PEND  = 8'h80;
    localparam periph_bus_pkg::reg_offset_t OFF_EN    = 8'h84;
    localparam periph_bus_pkg::reg_offset_t OFF_THR   = 8'h88;
    localparam periph_bus_pkg::reg_offset_t OFF_CLAIM = 8'h8C;

    periph_irq_pkg::prio_t          prio_q [NSRC];
    periph_irq_pkg::prio_t          thr_q;
    periph_irq_pkg::prio_t          best_prio;
    periph_irq_pkg::irq_id_t        best_id;
    periph_irq_pkg::irq_vec_t       pend_q;
    periph_irq_pkg::irq_vec_t       en_q;
    periph_irq_pkg::irq_vec_t       srv_q;
    periph_irq_pkg::irq_vec_t       claim_vec;
    periph_irq_pkg::irq_vec_t       done_vec;
    logic [`PERIPH_OFFSET_W-3:0]    word;
    logic                           prio_hit;
    logic                           wr;
    logic                           claim_rd;
    logic                           irq_q;

    // Priority registers sit at word index = id
    assign word     = offset_i[`PERIPH_OFFSET_W-1:2];
    assign prio_hit = (offset_i[1:0] == 2'b00) && (word != '0) && (int'(word) <= NSRC);
    assign wr       = req_i && write_i;
    assign claim_rd = req_i && !write_i && (offset_i == OFF_CLAIM);

    // --------------------
    // Arbitration
    // --------------------
    // Strict compare keeps ties on the lowest id
    always_comb begin
        best_id   = '0;
        best_prio = thr_q;
        for (int k = 0; k < NSRC; k++) begin
            if (pend_q[k] && en_q[k] && (prio_q[k] > best_prio)) begin
                best_id   = periph_irq_pkg::irq_id_t'(k + 1);
                best_prio = prio_q[k];
            end
        end
    end

    always_comb begin
        claim_vec = '0;
        done_vec  = '0;
        for (int k = 0; k < NSRC; k++) begin
            if (claim_rd && best_id == periph_irq_pkg::irq_id_t'(k + 1)) begin
                claim_vec[k] = 1'b1;
            end
            if (wr && offset_i == OFF_CLAIM && wdata_i == periph_bus_pkg::apb_data_t'(k + 1)) begin
                done_vec[k] = 1'b1;
            end
        end
    end

    // --------------------
    // Registers
    // --------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < NSRC; k++) begin
                prio_q[k] <= '0;
            end
            thr_q  <= '0;
            en_q   <= '0;
            pend_q <= '0;
            srv_q  <= '0;
            irq_q  <= 1'b0;
        end else begin
            for (int k = 0; k < NSRC; k++) begin
                if (wr && prio_hit && int'(word) == k + 1) begin
                    prio_q[k] <= wdata_i[`PERIPH_PRIO_W-1:0];
                end
            end
            if (wr && offset_i == OFF_EN) begin
                en_q <= wdata_i[NSRC-1:0];
            end
            if (wr && offset_i == OFF_THR) begin
                thr_q <= wdata_i[`PERIPH_PRIO_W-1:0];
            end
            // Level gateway blocked while in service
            pend_q <= (pend_q | (src_i & ~srv_q)) & ~claim_vec;
            srv_q  <= (srv_q | claim_vec) & ~done_vec;
            irq_q  <= (best_id != '0);
        end
    end

    always_comb begin
        rdata_o = '0;
        if (prio_hit) begin
            for (int k = 0; k < NSRC; k++) begin
                if (int'(word) == k + 1) begin
                    rdata_o = periph_bus_pkg::apb_data_t'(prio_q[k]);
                end
            end
        end else begin
            case (offset_i)
                OFF_PEND:  rdata_o = periph_bus_pkg::apb_data_t'(pend_q);
                OFF_EN:    rdata_o = periph_bus_pkg::apb_data_t'(en_q);
                OFF_THR:   rdata_o = periph_bus_pkg::apb_data_t'(thr_q);
                OFF_CLAIM: rdata_o = periph_bus_pkg::apb_data_t'(best_id);
                default:   rdata_o = '0;
            endcase
        end
    end

    assign irq_o = irq_q;

    a_claim_id_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        claim_rd |-> (rdata_o <= NSRC));

endmodule

`default_nettype wire

//--- logic/periph_bus_pkg.sv
`default_nettype none

`include "periph_cfg.svh"

package periph_bus_pkg;

    // --------------------
    // APB bus
    // --------------------
    typedef logic [`PERIPH_ADDR_W-1:0] apb_addr_t;
    typedef logic [`PERIPH_DATA_W-1:0] apb_data_t;

    // --------------------
    // Address map
    // --------------------
    // Byte offset inside one slot
    typedef logic [`PERIPH_OFFSET_W-1:0] reg_offset_t;

    // Target of a decoded transfer
    typedef enum logic [1:0] {
        SLOT_PLIC,
        SLOT_TIMER,
        SLOT_ERR
    } slot_e;

    // Access FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STROBE,
        ST_READY
    } access_state_e;

endpackage

`default_nettype wire

//--- logic/periph_cfg.svh
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// Bus widths
`define PERIPH_ADDR_W       12
`define PERIPH_DATA_W       32
`define PERIPH_OFFSET_W     8

// Peripheral counts and field widths
`define PERIPH_NUM_TIMERS   2
`define PERIPH_NUM_EXT_IRQ  2
`define PERIPH_PRIO_W       3
`define PERIPH_PRESCALE_W   8

// Slot bases
// Each slot spans one page of 1 << PERIPH_OFFSET_W bytes
`define PERIPH_PLIC_BASE    12'h000
`define PERIPH_TIMER_BASE   12'h100

// Read data of unmapped addresses
`define PERIPH_ERR_PATTERN  32'hDEAD_BEEF

`endif

//--- logic/periph_irq_pkg.sv
`default_nettype none

`include "periph_cfg.svh"

package periph_irq_pkg;

    // Timers first, then external lines
    localparam int NUM_SRC = `PERIPH_NUM_TIMERS + `PERIPH_NUM_EXT_IRQ;

    // --------------------
    // Interrupt sources
    // --------------------
    // Id 0 is reserved for no source
    typedef logic [$clog2(NUM_SRC+1)-1:0] irq_id_t;
    typedef logic [`PERIPH_PRIO_W-1:0]    prio_t;

    // Bit k belongs to id k+1
    typedef logic [NUM_SRC-1:0] irq_vec_t;

    // --------------------
    // Timers
    // --------------------
    typedef logic [`PERIPH_DATA_W-1:0]     tmr_count_t;
    typedef logic [`PERIPH_PRESCALE_W-1:0] prescale_t;

endpackage

`default_nettype wire

//--- logic/periph_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "periph_cfg.svh"

module periph_top (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    // APB slave
    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  periph_bus_pkg::apb_addr_t      paddr_i,
    input  periph_bus_pkg::apb_data_t      pwdata_i,
    output periph_bus_pkg::apb_data_t      prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o,
    // Interrupts
    input  logic [`PERIPH_NUM_EXT_IRQ-1:0] ext_irq_i,
    output logic                           irq_o
);

    logic                                plic_req;
    logic                                tmr_req;
    logic                                req_write;
    periph_bus_pkg::reg_offset_t         req_offset;
    periph_bus_pkg::apb_data_t           req_wdata;
    periph_bus_pkg::apb_data_t           plic_rdata;
    periph_bus_pkg::apb_data_t           tmr_rdata;
    logic [`PERIPH_NUM_TIMERS-1:0]       tmr_match;
    periph_irq_pkg::irq_vec_t            irq_src;

    // Timers take the low ids
    assign irq_src = {ext_irq_i, tmr_match};

    apb_access_fsm i_apb_access_fsm (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .psel_i       ( psel_i     ),
        .penable_i    ( penable_i  ),
        .pwrite_i     ( pwrite_i   ),
        .paddr_i      ( paddr_i    ),
        .pwdata_i     ( pwdata_i   ),
        .prdata_o     ( prdata_o   ),
        .pready_o     ( pready_o   ),
        .pslverr_o    ( pslverr_o  ),
        .plic_req_o   ( plic_req   ),
        .tmr_req_o    ( tmr_req    ),
        .req_write_o  ( req_write  ),
        .req_offset_o ( req_offset ),
        .req_wdata_o  ( req_wdata  ),
        .plic_rdata_i ( plic_rdata ),
        .tmr_rdata_i  ( tmr_rdata  )
    );

    timer_bank i_timer_bank (
        .clk_i    ( clk_i      ),
        .rst_n_i  ( rst_n_i    ),
        .req_i    ( tmr_req    ),
        .write_i  ( req_write  ),
        .offset_i ( req_offset ),
        .wdata_i  ( req_wdata  ),
        .rdata_o  ( tmr_rdata  ),
        .match_o  ( tmr_match  )
    );

    irq_controller i_irq_controller (
        .clk_i    ( clk_i      ),
        .rst_n_i  ( rst_n_i    ),
        .req_i    ( plic_req   ),
        .write_i  ( req_write  ),
        .offset_i ( req_offset ),
        .wdata_i  ( req_wdata  ),
        .rdata_o  ( plic_rdata ),
        .src_i    ( irq_src    ),
        .irq_o    ( irq_o      )
    );

endmodule

`default_nettype wire

//--- logic/timer_bank.sv
`default_nettype none
`timescale 1ns/1ps

`include "periph_cfg.svh"

module timer_bank (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          req_i,
    input  logic                          write_i,
    input  periph_bus_pkg::reg_offset_t   offset_i,
    input  periph_bus_pkg::apb_data_t     wdata_i,
    output periph_bus_pkg::apb_data_t     rdata_o,
    output logic [`PERIPH_NUM_TIMERS-1:0] match_o
);

    localparam int NT    = `PERIPH_NUM_TIMERS;
    // 16 bytes per timer
    localparam int IDX_W = `PERIPH_OFFSET_W - 4;

    localparam logic [1:0] REG_COUNT = 2'd0;
    localparam logic [1:0] REG_CMP   = 2'd1;
    localparam logic [1:0] REG_CTRL  = 2'd2;
    localparam logic [1:0] REG_STAT  = 2'd3;

    logic [IDX_W-1:0]          sel_idx;
    logic [1:0]                sel_reg;
    logic                      aligned;
    periph_bus_pkg::apb_data_t tmr_rd [NT];

    assign sel_idx = offset_i[`PERIPH_OFFSET_W-1:4];
    assign sel_reg = offset_i[3:2];
    assign aligned = (offset_i[1:0] == 2'b00);

    for (genvar i = 0; i < NT; i++) begin : g_tmr
        periph_irq_pkg::tmr_count_t count_q;
        periph_irq_pkg::tmr_count_t cmp_q;
        periph_irq_pkg::prescale_t  presc_q;
        periph_irq_pkg::prescale_t  pdiv_q;
        periph_bus_pkg::apb_data_t  rd_word;
        logic                       en_q;
        logic                       match_q;
        logic                       hit;
        logic                       tick;
        logic                       wrap;

        assign hit  = req_i && write_i && aligned && (sel_idx == IDX_W'(i));
        assign tick = en_q && (pdiv_q >= presc_q);
        // Wrap at or past compare
        assign wrap = (count_q >= cmp_q);

        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                count_q <= '0;
                cmp_q   <= '0;
                presc_q <= '0;
                pdiv_q  <= '0;
                en_q    <= 1'b0;
                match_q <= 1'b0;
            end else begin
                if (!en_q || tick) begin
                    pdiv_q <= '0;
                end else begin
                    pdiv_q <= pdiv_q + 1'b1;
                end

                if (hit && sel_reg == REG_COUNT) begin
                    count_q <= wdata_i;
                end else if (tick) begin
                    count_q <= wrap ? '0 : count_q + 1'b1;
                end

                if (hit && sel_reg == REG_CMP) begin
                    cmp_q <= wdata_i;
                end

                if (hit && sel_reg == REG_CTRL) begin
                    en_q    <= wdata_i[0];
                    presc_q <= wdata_i[15:8];
                end

                // A new match wins over a clear in the same cycle
                match_q <= (match_q && !(hit && sel_reg == REG_STAT && wdata_i[0]))
                           || (tick && wrap);
            end
        end

        always_comb begin
            case (sel_reg)
                REG_COUNT: rd_word = count_q;
                REG_CMP:   rd_word = cmp_q;
                REG_CTRL:  rd_word = periph_bus_pkg::apb_data_t'({presc_q, 7'b0, en_q});
                default:   rd_word = periph_bus_pkg::apb_data_t'(match_q);
            endcase
        end

        assign tmr_rd[i]  = rd_word;
        assign match_o[i] = match_q;

        a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            (en_q && cmp_q != '0) |-> (count_q <= cmp_q));
    end

    // Read mux
    always_comb begin
        rdata_o = '0;
        for (int i = 0; i < NT; i++) begin
            if (aligned && sel_idx == IDX_W'(i)) begin
                rdata_o = tmr_rd[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the periph_tb simulation with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module periph_tb \
    -f sources.f \
    -o periph_sim > build.log 2>&1 \
    && ./obj_dir/periph_sim > sim.log 2>&1 \
    || { cat build.log; echo "Build or run of the simulation failed"; exit 1; }

cat sim.log

grep -q "^Done: no errors$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- sim/periph_tb_tasks.svh
`ifndef PERIPH_TB_TASKS_SVH
`define PERIPH_TB_TASKS_SVH

// --------------------
// APB master
// --------------------
task automatic apb_xfer(input logic wr, input periph_bus_pkg::apb_addr_t addr,
                        input periph_bus_pkg::apb_data_t wdata,
                        output periph_bus_pkg::apb_data_t rdata, output logic err);
    int cnt;
    cnt = 0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready && cnt < APB_LIMIT) begin
        @(negedge clk);
        cnt++;
    end
    if (!pready) begin
        $display("Transfer at address %h never saw pready_o", addr);
        timed_out = 1'b1;
    end else if (cnt != 1) begin
        // Access phase is two cycles long
        $display("Transfer at address %h saw pready_o %0d cycles after the first access cycle",
                 addr, cnt);
        errors++;
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

// Waits on negedges for irq_o to reach a level
task automatic wait_irq(input logic level);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (irq !== level && cnt < IRQ_LIMIT) begin
        @(negedge clk);
        cnt++;
    end
    if (irq !== level) begin
        $display("irq_o did not reach %0b in %0d cycles", level, IRQ_LIMIT);
    end
endtask

// --------------------
// Compare tasks
// --------------------
task automatic check_data(input string name, input periph_bus_pkg::apb_data_t got,
                          input periph_bus_pkg::apb_data_t exp);
    checks++;
    if (got !== exp) begin
        $display("ERROR %s: got %h, expected %h", name, got, exp);
        errors++;
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        $display("ERROR %s: got %h, expected %h", name, got, exp);
        errors++;
    end
endtask

task automatic check_id(input string name, input periph_irq_pkg::irq_id_t got,
                        input periph_irq_pkg::irq_id_t exp);
    checks++;
    if (got !== exp) begin
        $display("ERROR %s: got %h, expected %h", name, got, exp);
        errors++;
    end
endtask

`endif

//--- sim/periph_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "periph_cfg.svh"

module periph_tb;

    localparam int APB_LIMIT  = 16;
    localparam int IRQ_LIMIT  = 64;
    localparam int POLL_LIMIT = 60;

    localparam periph_bus_pkg::apb_addr_t PEND_ADDR  = 12'h080;
    localparam periph_bus_pkg::apb_addr_t EN_ADDR    = 12'h084;
    localparam periph_bus_pkg::apb_addr_t THR_ADDR   = 12'h088;
    localparam periph_bus_pkg::apb_addr_t CLAIM_ADDR = 12'h08C;
    localparam periph_bus_pkg::apb_data_t ALL        = 32'hFFFF_FFFF;

    typedef enum int {OP_WR, OP_RD, OP_RDX, OP_POLL, OP_EXT, OP_IRQ} op_e;

    typedef struct {
        int                        test;
        op_e                       op;
        periph_bus_pkg::apb_addr_t addr;
        periph_bus_pkg::apb_data_t data;
        periph_bus_pkg::apb_data_t mask;
        periph_bus_pkg::apb_data_t exp;
        logic                      exp_err;
        logic                      exp_irq;
    } row_t;

    logic                           clk;
    logic                           rst_n;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    periph_bus_pkg::apb_addr_t      paddr;
    periph_bus_pkg::apb_data_t      pwdata;
    periph_bus_pkg::apb_data_t      prdata;
    logic                           pready;
    logic                           pslverr;
    logic [`PERIPH_NUM_EXT_IRQ-1:0] ext_irq;
    logic                           irq;

    row_t rows[$];
    int   checks;
    int   errors;
    logic timed_out;

    periph_top u_dut (
        .clk_i     ( clk     ),
        .rst_n_i   ( rst_n   ),
        .psel_i    ( psel    ),
        .penable_i ( penable ),
        .pwrite_i  ( pwrite  ),
        .paddr_i   ( paddr   ),
        .pwdata_i  ( pwdata  ),
        .prdata_o  ( prdata  ),
        .pready_o  ( pready  ),
        .pslverr_o ( pslverr ),
        .ext_irq_i ( ext_irq ),
        .irq_o     ( irq     )
    );

    `include "periph_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic void add(input int test, input op_e op, input int addr,
                                input int data, input int mask, input int exp,
                                input logic err, input logic irq_lvl);
        row_t r;
        r.test    = test;
        r.op      = op;
        r.addr    = periph_bus_pkg::apb_addr_t'(addr);
        r.data    = data;
        r.mask    = mask;
        r.exp     = exp;
        r.exp_err = err;
        r.exp_irq = irq_lvl;
        rows.push_back(r);
    endfunction

    // --------------------
    // Stimulus table
    // --------------------
    function automatic void build_table();
        int v;
        int cmp;
        int presc;
        int pa;
        int pb;
        // Reset values (test 1)
        for (int a = 4; a <= 'h10; a += 4) add(1, OP_RDX, a, 0, ALL, 0, 0, 0);
        for (int a = 'h80; a <= 'h8C; a += 4) add(1, OP_RDX, a, 0, ALL, 0, 0, 0);
        for (int a = 'h100; a <= 'h11C; a += 4) add(1, OP_RDX, a, 0, ALL, 0, 0, 0);
        add(1, OP_IRQ, 0, 0, 0, 0, 0, 0);
        // Register read-back masked to field widths (test 2)
        for (int id = 1; id <= 4; id++) begin
            v = $urandom;
            add(2, OP_WR, id * 4, v, 0, 0, 0, 0);
            add(2, OP_RDX, id * 4, 0, ALL, v & 7, 0, 0);
        end
        v = $urandom;
        add(2, OP_WR, EN_ADDR, v, 0, 0, 0, 0);
        add(2, OP_RDX, EN_ADDR, 0, ALL, v & 'hF, 0, 0);
        v = $urandom;
        add(2, OP_WR, THR_ADDR, v, 0, 0, 0, 0);
        add(2, OP_RDX, THR_ADDR, 0, ALL, v & 7, 0, 0);
        for (int t = 0; t < 2; t++) begin
            v = $urandom;
            add(2, OP_WR, 'h104 + 16 * t, v, 0, 0, 0, 0);
            add(2, OP_RDX, 'h104 + 16 * t, 0, ALL, v, 0, 0);
            v = $urandom;
            add(2, OP_WR, 'h108 + 16 * t, v, 0, 0, 0, 0);
            add(2, OP_RDX, 'h108 + 16 * t, 0, ALL, v & 'hFF01, 0, 0);
        end
        // Back to a quiet state
        for (int t = 0; t < 2; t++) begin
            add(2, OP_WR, 'h108 + 16 * t, 0, 0, 0, 0, 0);
            add(2, OP_WR, 'h100 + 16 * t, 0, 0, 0, 0, 0);
            add(2, OP_WR, 'h104 + 16 * t, 0, 0, 0, 0, 0);
            add(2, OP_WR, 'h10C + 16 * t, 1, 0, 0, 0, 0);
        end
        for (int id = 1; id <= 4; id++) add(2, OP_WR, id * 4, 0, 0, 0, 0, 0);
        add(2, OP_WR, EN_ADDR, 0, 0, 0, 0, 0);
        add(2, OP_WR, THR_ADDR, 0, 0, 0, 0, 0);
        // Unmapped slots (test 3)
        add(3, OP_RDX, 'h200, 0, ALL, `PERIPH_ERR_PATTERN, 1, 0);
        add(3, OP_WR, 'h300, $urandom, 0, 0, 1, 0);
        add(3, OP_RDX, 'hFFC, 0, ALL, `PERIPH_ERR_PATTERN, 1, 0);
        add(3, OP_RD, 'h088, 0, 0, 0, 0, 0);
        add(3, OP_RDX, 'h11C, 0, ALL, 0, 0, 0);
        // Timer 0 match and its interrupt (test 4)
        cmp   = 1 + $urandom % 8;
        presc = $urandom % 4;
        add(4, OP_WR, 'h100, 0, 0, 0, 0, 0);
        add(4, OP_WR, 'h104, cmp, 0, 0, 0, 0);
        add(4, OP_WR, 'h108, (presc << 8) | 1, 0, 0, 0, 0);
        add(4, OP_POLL, 'h10C, 0, 1, 1, 0, 0);
        add(4, OP_WR, 'h108, 0, 0, 0, 0, 0);
        add(4, OP_WR, 'h10C, 1, 0, 0, 0, 0);
        add(4, OP_RDX, 'h10C, 0, 1, 0, 0, 0);
        add(4, OP_WR, 'h004, 1 + $urandom % 7, 0, 0, 0, 0);
        add(4, OP_WR, EN_ADDR, 1, 0, 0, 0, 0);
        add(4, OP_IRQ, 0, 0, 0, 0, 0, 1);
        add(4, OP_RDX, CLAIM_ADDR, 0, ALL, 1, 0, 0);
        add(4, OP_IRQ, 0, 0, 0, 0, 0, 0);
        add(4, OP_WR, CLAIM_ADDR, 1, 0, 0, 0, 0);
        // External sources at ids 3 and 4 (test 5)
        pa = 1 + $urandom % 7;
        pb = 1 + (pa + $urandom % 6) % 7;
        add(5, OP_WR, 'h00C, pa, 0, 0, 0, 0);
        add(5, OP_WR, 'h010, pb, 0, 0, 0, 0);
        add(5, OP_WR, EN_ADDR, 'hC, 0, 0, 0, 0);
        add(5, OP_EXT, 0, 3, 0, 0, 0, 0);
        add(5, OP_IRQ, 0, 0, 0, 0, 0, 1);
        add(5, OP_RDX, CLAIM_ADDR, 0, ALL, (pa > pb) ? 3 : 4, 0, 0);
        add(5, OP_RDX, CLAIM_ADDR, 0, ALL, (pa > pb) ? 4 : 3, 0, 0);
        add(5, OP_IRQ, 0, 0, 0, 0, 0, 0);
        add(5, OP_WR, CLAIM_ADDR, 3, 0, 0, 0, 0);
        add(5, OP_WR, CLAIM_ADDR, 4, 0, 0, 0, 0);
        add(5, OP_POLL, PEND_ADDR, 0, 'hC, 'hC, 0, 0);
        add(5, OP_IRQ, 0, 0, 0, 0, 0, 1);
        add(5, OP_WR, THR_ADDR, (pa > pb) ? pa : pb, 0, 0, 0, 0);
        add(5, OP_IRQ, 0, 0, 0, 0, 0, 0);
        add(5, OP_RDX, CLAIM_ADDR, 0, ALL, 0, 0, 0);
        add(5, OP_EXT, 0, 0, 0, 0, 0, 0);
    endfunction

    // --------------------
    // Apply loop
    // --------------------
    initial begin
        periph_bus_pkg::apb_data_t rdata;
        logic                      err;
        int                        cur_test;
        int                        test_err;
        int                        tries;
        void'($urandom(55952));
        checks    = 0;
        errors    = 0;
        timed_out = 1'b0;
        rst_n   <= 1'b0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        ext_irq <= '0;
        build_table();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        cur_test = rows[0].test;
        test_err = 0;
        foreach (rows[i]) begin
            if (timed_out) break;
            if (rows[i].test != cur_test) begin
                $display("Test %0d finished with %0d errors", cur_test, errors - test_err);
                cur_test = rows[i].test;
                test_err = errors;
            end
            case (rows[i].op)
                OP_WR: begin
                    apb_xfer(1'b1, rows[i].addr, rows[i].data, rdata, err);
                    check_flag("pslverr_o", err, rows[i].exp_err);
                end
                OP_RD: begin
                    apb_xfer(1'b0, rows[i].addr, '0, rdata, err);
                    check_flag("pslverr_o", err, rows[i].exp_err);
                end
                OP_RDX: begin
                    apb_xfer(1'b0, rows[i].addr, '0, rdata, err);
                    check_data("prdata_o", rdata & rows[i].mask, rows[i].exp);
                    check_flag("pslverr_o", err, rows[i].exp_err);
                    if (rows[i].addr == CLAIM_ADDR) begin
                        check_id("claim id", periph_irq_pkg::irq_id_t'(rdata),
                                 periph_irq_pkg::irq_id_t'(rows[i].exp));
                    end
                end
                OP_POLL: begin
                    tries = 0;
                    do begin
                        apb_xfer(1'b0, rows[i].addr, '0, rdata, err);
                        tries++;
                    end while ((rdata & rows[i].mask) != rows[i].exp && tries < POLL_LIMIT
                               && !timed_out);
                    if ((rdata & rows[i].mask) != rows[i].exp) begin
                        $display("Polling address %h timed out after %0d reads",
                                 rows[i].addr, tries);
                        errors++;
                    end
                end
                OP_EXT: begin
                    @(posedge clk);
                    ext_irq <= rows[i].data[`PERIPH_NUM_EXT_IRQ-1:0];
                end
                default: begin
                    wait_irq(rows[i].exp_irq);
                    check_flag("irq_o", irq, rows[i].exp_irq);
                end
            endcase
        end
        if (timed_out) begin
            errors++;
        end else begin
            $display("Test %0d finished with %0d errors", cur_test, errors - test_err);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
+incdir+sim
logic/periph_bus_pkg.sv
logic/periph_irq_pkg.sv
logic/apb_access_fsm.sv
logic/timer_bank.sv
logic/irq_controller.sv
logic/periph_top.sv
sim/periph_tb.sv
